//--- build.f
+incdir+hdl
hdl/wb2sdrc_pkg.sv
hdl/sync_fifo.sv
hdl/wb_req_ctrl.sv
hdl/wb2sdrc.sv
verification/wb2sdrc_properties.sv
verification/wb2sdrc_tb.sv

//--- hdl/sync_fifo.sv
/*
 * Show-ahead synchronous FIFO, head entry visible without a pop.
 * DEPTH must be a power of two.
 * Push while full and pop while empty are ignored.
 * Push and pop may happen in the same cycle.
 */
module sync_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic sdram_clk,
	input logic wb_clk_i,

	// write side
	input logic push_i,
	input T push_data_i,

	// read side
	input logic pop_i,
	output T pop_data_o,

	// status
	output logic full_o,
	output logic empty_o
);

	// --------------------------------------------------
	// storage and pointers
	// --------------------------------------------------
	// address bits of the buffer
	localparam int AW = $clog2(DEPTH);

	// payload only, no reset needed
	T mem [DEPTH];

	// one extra wrap bit to split full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	// qualified strobes
	logic do_push;
	logic do_pop;

	// --------------------------------------------------
	// status flags
	// --------------------------------------------------
	// same slot, same lap
	assign empty_o = (wr_ptr == rd_ptr);

	// same slot, writer one lap ahead
	assign full_o = (wr_ptr[AW] != rd_ptr[AW]) &&
		(wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	// --------------------------------------------------
	// write side
	// --------------------------------------------------
	always_ff @(posedge sdram_clk) begin
		if (do_push) begin
			mem[wr_ptr[AW-1:0]] <= push_data_i;
		end
	end

	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			wr_ptr <= '0;
		end else if (do_push) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			rd_ptr <= '0;
		end else if (do_pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// head entry shown straight from the buffer
	// only meaningful while not empty
	assign pop_data_o = mem[rd_ptr[AW-1:0]];

endmodule

//--- hdl/wb2sdrc.sv
/*
 * Wishbone to SDRAM controller request bridge.
 * Classic single reads and writes only, no bursts.
 * Controller side assumes single transfers per request.
 * Controller strobes are one-cycle pulses and must not
 * hit an empty or full queue.
 */
`include "wb2sdrc_settings.svh"

module wb2sdrc (
	input logic sdram_clk,
	input logic wb_clk_i,

	// --------------------------------------------------
	// wishbone slave
	// --------------------------------------------------
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input wb2sdrc_pkg::sdr_addr_t wb_addr_i,
	input wb2sdrc_pkg::sdr_data_t wb_dat_i,
	input logic [$bits(wb2sdrc_pkg::sdr_mask_t)-1:0] wb_sel_i,
	output logic wb_ack_o,
	output wb2sdrc_pkg::sdr_data_t wb_dat_o,

	// --------------------------------------------------
	// sdram controller request side
	// --------------------------------------------------
	input logic sdr_req_ack_i,
	input logic sdr_wr_next_i,
	input logic sdr_rd_valid_i,
	input wb2sdrc_pkg::sdr_data_t sdr_rd_data_i,
	output logic sdr_req_o,
	output wb2sdrc_pkg::sdr_cmd_t sdr_cmd_o,
	output wb2sdrc_pkg::sdr_wr_t sdr_wr_o
);

	// command queue
	logic cmd_push;
	wb2sdrc_pkg::sdr_cmd_t cmd_in;
	logic cmd_full;
	logic cmd_empty;

	// write data queue
	logic wrdata_push;
	wb2sdrc_pkg::sdr_wr_t wrdata_in;
	logic wrdata_full;
	logic wrdata_empty;

	// read data queue
	logic rddata_pop;
	logic rddata_full;
	logic rddata_empty;

	// --------------------------------------------------
	// wishbone decode
	// --------------------------------------------------
	wb_req_ctrl u_req_ctrl (
		.sdram_clk      (sdram_clk),
		.wb_clk_i       (wb_clk_i),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.wb_we_i        (wb_we_i),
		.wb_addr_i      (wb_addr_i),
		.wb_dat_i       (wb_dat_i),
		.wb_sel_i       (wb_sel_i),
		.wb_ack_o       (wb_ack_o),
		.cmd_full_i     (cmd_full),
		.wrdata_full_i  (wrdata_full),
		.rddata_empty_i (rddata_empty),
		.cmd_push_o     (cmd_push),
		.cmd_o          (cmd_in),
		.wrdata_push_o  (wrdata_push),
		.wrdata_o       (wrdata_in),
		.rddata_pop_o   (rddata_pop)
	);

	// --------------------------------------------------
	// command queue, popped by the request ack
	// --------------------------------------------------
	sync_fifo #(
		.T     (wb2sdrc_pkg::sdr_cmd_t),
		.DEPTH (`WB2SDRC_CMD_DEPTH)
	) u_cmdfifo (
		.sdram_clk   (sdram_clk),
		.wb_clk_i    (wb_clk_i),
		.push_i      (cmd_push),
		.push_data_i (cmd_in),
		.pop_i       (sdr_req_ack_i),
		.pop_data_o  (sdr_cmd_o),
		.full_o      (cmd_full),
		.empty_o     (cmd_empty)
	);

	// request held high until the head is acked
	assign sdr_req_o = !cmd_empty;

	// --------------------------------------------------
	// write data queue, popped by wr_next
	// --------------------------------------------------
	sync_fifo #(
		.T     (wb2sdrc_pkg::sdr_wr_t),
		.DEPTH (`WB2SDRC_WR_DEPTH)
	) u_wrdatafifo (
		.sdram_clk   (sdram_clk),
		.wb_clk_i    (wb_clk_i),
		.push_i      (wrdata_push),
		.push_data_i (wrdata_in),
		.pop_i       (sdr_wr_next_i),
		.pop_data_o  (sdr_wr_o),
		.full_o      (wrdata_full),
		.empty_o     (wrdata_empty)
	);

	// --------------------------------------------------
	// read data queue, filled by rd_valid
	// --------------------------------------------------
	sync_fifo #(
		.T     (wb2sdrc_pkg::sdr_data_t),
		.DEPTH (`WB2SDRC_RD_DEPTH)
	) u_rddatafifo (
		.sdram_clk   (sdram_clk),
		.wb_clk_i    (wb_clk_i),
		.push_i      (sdr_rd_valid_i),
		.push_data_i (sdr_rd_data_i),
		.pop_i       (rddata_pop),
		.pop_data_o  (wb_dat_o),
		.full_o      (rddata_full),
		.empty_o     (rddata_empty)
	);

endmodule

//--- hdl/wb2sdrc_pkg.sv
/*
 * Payload types shared by the bridge and its testbench.
 * Widths follow the macros in the settings header.
 * Byte mask is active low, one bit per byte lane.
 */
`include "wb2sdrc_settings.svh"

package wb2sdrc_pkg;

	// --------------------------------------------------
	// basic words
	// --------------------------------------------------
	// application word address
	typedef logic [`WB2SDRC_AW-1:0] sdr_addr_t;
	// one data word
	typedef logic [`WB2SDRC_DW-1:0] sdr_data_t;
	// 0 = byte lane written
	typedef logic [`WB2SDRC_DW/8-1:0] sdr_mask_t;

	// --------------------------------------------------
	// queue entries
	// --------------------------------------------------
	// command toward the controller
	typedef struct packed {
		logic wr_n;        // 1 = read, 0 = write
		sdr_addr_t addr;
	} sdr_cmd_t;

	// write word with its byte mask
	typedef struct packed {
		sdr_mask_t en_n;
		sdr_data_t data;
	} sdr_wr_t;

endpackage

//--- hdl/wb2sdrc_settings.svh
/*
 * Sizing for the Wishbone to SDRAM controller request bridge.
 * FIFO depths must be powers of two.
 * Data width must be a whole number of bytes.
 */
`ifndef WB2SDRC_SETTINGS_SVH
`define WB2SDRC_SETTINGS_SVH

// --------------------------------------------------
// bus widths
// --------------------------------------------------
// application word address
`define WB2SDRC_AW 26
// data word, byte lanes = DW / 8
`define WB2SDRC_DW 32

// --------------------------------------------------
// queue depths
// --------------------------------------------------
`define WB2SDRC_CMD_DEPTH 4
`define WB2SDRC_WR_DEPTH 8
`define WB2SDRC_RD_DEPTH 4

`endif

//--- hdl/wb_req_ctrl.sv
/*
 * Turns classic single Wishbone cycles into queue strobes.
 * Writes are acked at once when both write queues have room.
 * Reads are acked when returned data sits in the read queue.
 * Only one read may be outstanding at a time.
 */
module wb_req_ctrl (
	input logic sdram_clk,
	input logic wb_clk_i,

	// wishbone slave side
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input wb2sdrc_pkg::sdr_addr_t wb_addr_i,
	input wb2sdrc_pkg::sdr_data_t wb_dat_i,
	input wb2sdrc_pkg::sdr_mask_t wb_sel_i,
	output logic wb_ack_o,

	// queue status
	input logic cmd_full_i,
	input logic wrdata_full_i,
	input logic rddata_empty_i,

	// queue strobes and entries
	output logic cmd_push_o,
	output wb2sdrc_pkg::sdr_cmd_t cmd_o,
	output logic wrdata_push_o,
	output wb2sdrc_pkg::sdr_wr_t wrdata_o,
	output logic rddata_pop_o
);

	// --------------------------------------------------
	// cycle decode
	// --------------------------------------------------
	logic wr_req;
	logic rd_req;
	logic wr_ack;
	logic rd_ack;
	logic rd_cmd_push;

	// read command already queued, waiting for data
	logic pending_read;

	assign wr_req = wb_cyc_i && wb_stb_i && wb_we_i;
	assign rd_req = wb_cyc_i && wb_stb_i && !wb_we_i;

	// write goes through only if command and data both fit
	assign wr_ack = wr_req && !cmd_full_i && !wrdata_full_i;

	// read ends when its word has come back
	assign rd_ack = rd_req && !rddata_empty_i;

	assign wb_ack_o = wr_ack || rd_ack;

	// --------------------------------------------------
	// queue strobes
	// --------------------------------------------------
	// held read request queues its command only once
	assign rd_cmd_push = rd_req && !cmd_full_i && !pending_read;

	assign cmd_push_o = wr_ack || rd_cmd_push;
	assign wrdata_push_o = wr_ack;
	assign rddata_pop_o = rd_ack;

	// set on the command push, cleared by the read ack
	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			pending_read <= 1'b0;
		end else if (rd_cmd_push) begin
			pending_read <= 1'b1;
		end else if (rd_ack) begin
			pending_read <= 1'b0;
		end
	end

	// --------------------------------------------------
	// queue entries
	// --------------------------------------------------
	assign cmd_o.wr_n = !wb_we_i;
	assign cmd_o.addr = wb_addr_i;

	// wishbone select is active high, controller mask active low
	assign wrdata_o.en_n = ~wb_sel_i;
	assign wrdata_o.data = wb_dat_i;

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the bridge testbench with Verilator.
# Exits non-zero unless the run reports the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
	-f build.f --top-module wb2sdrc_tb -o Vwb2sdrc_tb
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vwb2sdrc_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
	exit 0
fi
echo "pass message not found"
exit 1

//--- verification/wb2sdrc_properties.sv
/*
 * Overflow and underflow rules for the bridge queues.
 * Bound into every wb2sdrc instance, checked on sdram_clk.
 * Rules are idle while wb_clk_i holds the design in reset.
 */
module wb2sdrc_properties (
	input logic sdram_clk,
	input logic wb_clk_i,
	input logic cmd_push_i,
	input logic cmd_full_i,
	input logic sdr_req_ack_i,
	input logic sdr_req_i,
	input logic sdr_wr_next_i,
	input logic wrdata_empty_i,
	input logic sdr_rd_valid_i,
	input logic rddata_full_i
);

	// --------------------------------------------------
	// queue rules
	// --------------------------------------------------
	// command queue never pushed past its depth
	a_cmd_no_overflow: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		!(cmd_push_i && cmd_full_i))
		else $error("command pushed into a full command queue");

	// controller acks only a presented request
	a_ack_needs_req: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		!(sdr_req_ack_i && !sdr_req_i))
		else $error("request ack with no request pending");

	// write word must be there when taken
	a_wr_no_underflow: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		!(sdr_wr_next_i && wrdata_empty_i))
		else $error("write data taken from an empty queue");

	// returned read words need room
	a_rd_no_overflow: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		!(sdr_rd_valid_i && rddata_full_i))
		else $error("read data pushed into a full read queue");

endmodule

bind wb2sdrc wb2sdrc_properties u_props (
	.sdram_clk      (sdram_clk),
	.wb_clk_i       (wb_clk_i),
	.cmd_push_i     (cmd_push),
	.cmd_full_i     (cmd_full),
	.sdr_req_ack_i  (sdr_req_ack_i),
	.sdr_req_i      (sdr_req_o),
	.sdr_wr_next_i  (sdr_wr_next_i),
	.wrdata_empty_i (wrdata_empty),
	.sdr_rd_valid_i (sdr_rd_valid_i),
	.rddata_full_i  (rddata_full)
);

//--- verification/wb2sdrc_stim.txt
# test op addr data sel expected, all but the test number in hex
# op W write, R read, B five writes from addr with the command acks stalled
1 W 0000010 11223344 f 00000000
2 W 0000011 aabbccdd f 00000000
3 W 0000010 000000ee 1 00000000
4 R 0000010 00000000 0 112233ee
5 W 0000011 55660000 c 00000000
6 R 0000011 00000000 0 5566ccdd
7 B 0000020 a0000000 f 00000000
8 R 0000022 00000000 0 a0000002
9 R 0000040 00000000 0 00000000
10 W 3ffffff deadbeef 6 00000000
11 R 3ffffff 00000000 0 00adbe00

//--- verification/wb2sdrc_tb.sv
/*
 * Testbench for the Wishbone to SDRAM controller bridge.
 * Operations and expected read words come from the stim file,
 * read from the project root.
 * The SDRAM controller is a simple behavioral model with a
 * word memory, random ack delay and a stall switch.
 */
`include "wb2sdrc_settings.svh"

module wb2sdrc_tb;

	logic sdram_clk;
	logic wb_clk_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	wb2sdrc_pkg::sdr_addr_t wb_addr_i;
	wb2sdrc_pkg::sdr_data_t wb_dat_i;
	logic [`WB2SDRC_DW/8-1:0] wb_sel_i;
	logic wb_ack_o;
	wb2sdrc_pkg::sdr_data_t wb_dat_o;
	logic sdr_req_ack_i;
	logic sdr_wr_next_i;
	logic sdr_rd_valid_i;
	wb2sdrc_pkg::sdr_data_t sdr_rd_data_i;
	logic sdr_req_o;
	wb2sdrc_pkg::sdr_cmd_t sdr_cmd_o;
	wb2sdrc_pkg::sdr_wr_t sdr_wr_o;

	// expected controller traffic, in order
	wb2sdrc_pkg::sdr_cmd_t exp_cmd_q[$];
	wb2sdrc_pkg::sdr_wr_t exp_wr_q[$];

	// controller model state
	wb2sdrc_pkg::sdr_data_t sdram_mem [wb2sdrc_pkg::sdr_addr_t];
	int seed = 13358;
	logic stall;
	int wait_cnt;
	int rd_cnt;
	wb2sdrc_pkg::sdr_addr_t rd_addr;
	int rd_cmd_seen;

	int errors;

	wb2sdrc uut (.*);

	initial begin
		sdram_clk = 1'b0;
		forever #20 sdram_clk = ~sdram_clk;
	end

	// --------------------------------------------------
	// sdram controller model
	// --------------------------------------------------
	always @(negedge sdram_clk) begin
		wb2sdrc_pkg::sdr_data_t word;
		sdr_req_ack_i = 1'b0;
		sdr_wr_next_i = 1'b0;
		sdr_rd_valid_i = 1'b0;
		// read word comes back two cycles after its ack
		if (rd_cnt > 0) begin
			rd_cnt--;
			if (rd_cnt == 0) begin
				sdr_rd_valid_i = 1'b1;
				sdr_rd_data_i = sdram_mem.exists(rd_addr) ? sdram_mem[rd_addr] : '0;
			end
		end
		if (!wb_clk_i && sdr_req_o && (!stall || wait_cnt >= 0)) begin
			if (wait_cnt < 0) begin
				wait_cnt = $random(seed) & 3;
			end
			if (wait_cnt == 0) begin
				sdr_req_ack_i = 1'b1;
				wait_cnt = -1;
				if (exp_cmd_q.size() == 0) begin
					$display("unexpected command at the controller at time %0t", $time);
					errors++;
				end else begin
					if (sdr_cmd_o !== exp_cmd_q[0]) begin
						$display("CHECK FAILED time %0t sdr_cmd_o expected %h actual %h",
							$time, exp_cmd_q[0], sdr_cmd_o);
						errors++;
					end
					void'(exp_cmd_q.pop_front());
				end
				if (sdr_cmd_o.wr_n) begin
					rd_cmd_seen++;
					rd_addr = sdr_cmd_o.addr;
					rd_cnt = 2;
				end else begin
					sdr_wr_next_i = 1'b1;
					if (exp_wr_q.size() == 0 || sdr_wr_o !== exp_wr_q[0]) begin
						$display("CHECK FAILED time %0t sdr_wr_o expected %h actual %h",
							$time, (exp_wr_q.size() > 0) ? exp_wr_q[0] : '0, sdr_wr_o);
						errors++;
					end
					if (exp_wr_q.size() > 0) begin
						void'(exp_wr_q.pop_front());
					end
					// byte merge where the mask bit is low
					word = sdram_mem.exists(sdr_cmd_o.addr) ? sdram_mem[sdr_cmd_o.addr] : '0;
					for (int b = 0; b < `WB2SDRC_DW / 8; b++) begin
						if (!sdr_wr_o.en_n[b]) begin
							word[8*b +: 8] = sdr_wr_o.data[8*b +: 8];
						end
					end
					sdram_mem[sdr_cmd_o.addr] = word;
				end
			end else begin
				wait_cnt--;
			end
		end
	end

	// --------------------------------------------------
	// wishbone master
	// --------------------------------------------------
	// one classic cycle, held until ack or max_cycles
	task automatic wb_cycle(input logic we, input wb2sdrc_pkg::sdr_addr_t addr,
		input wb2sdrc_pkg::sdr_data_t data, input wb2sdrc_pkg::sdr_mask_t sel,
		input int max_cycles, output logic acked, output wb2sdrc_pkg::sdr_data_t rdata);
		int n;
		wb2sdrc_pkg::sdr_cmd_t cmd;
		wb2sdrc_pkg::sdr_wr_t wr;
		acked = 1'b0;
		rdata = '0;
		n = 0;
		cmd.wr_n = !we;
		cmd.addr = addr;
		wr.en_n = ~sel;
		wr.data = data;
		@(negedge sdram_clk);
		if (!we) begin
			exp_cmd_q.push_back(cmd);
		end
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_addr_i = addr;
		wb_dat_i = data;
		wb_sel_i = sel;
		while (!acked && n < max_cycles) begin
			// mid low phase, before the next rising edge
			#10;
			if (wb_ack_o) begin
				acked = 1'b1;
				rdata = wb_dat_o;
				if (we) begin
					exp_cmd_q.push_back(cmd);
					exp_wr_q.push_back(wr);
				end
			end
			@(negedge sdram_clk);
			n++;
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	// all queued commands taken and no read in flight
	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while ((exp_cmd_q.size() != 0 || rd_cnt != 0) && n < max_cycles) begin
			@(negedge sdram_clk);
			n++;
		end
		if (exp_cmd_q.size() != 0 || rd_cnt != 0) begin
			$display("timeout: controller side did not drain at time %0t", $time);
			errors++;
		end
	endtask

	task automatic report_ack(input logic acked, input string what);
		if (!acked) begin
			$display("timeout: no wb_ack_o for %s at time %0t", what, $time);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		int fd;
		int tnum;
		int n_tests;
		int n_failed;
		int rd_lines;
		int err_before;
		int fields;
		string line;
		logic [7:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] sel;
		logic [31:0] expw;
		logic acked;
		wb2sdrc_pkg::sdr_data_t rdata;

		wb_clk_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_addr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		sdr_req_ack_i = 1'b0;
		sdr_wr_next_i = 1'b0;
		sdr_rd_valid_i = 1'b0;
		sdr_rd_data_i = '0;
		stall = 1'b0;
		wait_cnt = -1;
		rd_cnt = 0;
		rd_addr = '0;
		rd_cmd_seen = 0;
		errors = 0;
		n_tests = 0;
		n_failed = 0;
		rd_lines = 0;

		repeat (4) @(negedge sdram_clk);
		wb_clk_i = 1'b0;

		// idle outputs right after reset
		@(negedge sdram_clk);
		#10;
		err_before = errors;
		if (sdr_req_o !== 1'b0) begin
			$display("CHECK FAILED time %0t sdr_req_o expected 0 actual %b", $time, sdr_req_o);
			errors++;
		end
		if (wb_ack_o !== 1'b0) begin
			$display("CHECK FAILED time %0t wb_ack_o expected 0 actual %b", $time, wb_ack_o);
			errors++;
		end
		n_tests++;
		if (errors != err_before) n_failed++;
		$display("test 0 reset: %s", (errors == err_before) ? "ok" : "FAILED");

		fd = $fopen("verification/wb2sdrc_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stim file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line.substr(0, 0) == "#") continue;
				fields = $sscanf(line, "%d %s %h %h %h %h", tnum, op, addr, data, sel, expw);
				if (fields != 6) begin
					$display("malformed stim line: %s", line);
					errors++;
					continue;
				end
				err_before = errors;
				if (op == "W") begin
					wb_cycle(1'b1, addr, data, sel, 20, acked, rdata);
					report_ack(acked, "write");
				end else if (op == "R") begin
					rd_lines++;
					wb_cycle(1'b0, addr, '0, '0, 60, acked, rdata);
					report_ack(acked, "read");
					if (acked && rdata !== expw) begin
						$display("CHECK FAILED time %0t wb_dat_o expected %h actual %h",
							$time, expw, rdata);
						errors++;
					end
				end else begin
					// back-pressure: stall the controller, fill the command queue
					wait_drain(100);
					stall = 1'b1;
					for (int i = 0; i < `WB2SDRC_CMD_DEPTH; i++) begin
						wb_cycle(1'b1, addr + i, data + i, sel, 20, acked, rdata);
						report_ack(acked, "write under stall");
					end
					wb_cycle(1'b1, addr + `WB2SDRC_CMD_DEPTH, data + `WB2SDRC_CMD_DEPTH,
						sel, 10, acked, rdata);
					if (acked) begin
						$display("write past a full command queue was acknowledged");
						errors++;
					end
					stall = 1'b0;
					wb_cycle(1'b1, addr + `WB2SDRC_CMD_DEPTH, data + `WB2SDRC_CMD_DEPTH,
						sel, 20, acked, rdata);
					report_ack(acked, "held write after resume");
				end
				wait_drain(100);
				n_tests++;
				if (errors != err_before) n_failed++;
				$display("test %0d %s: %s", tnum, (op == "W") ? "write" :
					(op == "R") ? "read" : "back-pressure",
					(errors == err_before) ? "ok" : "FAILED");
			end
			$fclose(fd);
		end

		// one command per held read
		err_before = errors;
		if (rd_cmd_seen != rd_lines) begin
			$display("CHECK FAILED time %0t rd_cmd_seen expected %0d actual %0d",
				$time, rd_lines, rd_cmd_seen);
			errors++;
		end
		n_tests++;
		if (errors != err_before) n_failed++;
		$display("test read commands: %s", (errors == err_before) ? "ok" : "FAILED");

		$display("tests run %0d, tests failed %0d, failed checks %0d",
			n_tests, n_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
